// File: source/riscv_pkg.sv
// Shared widths, opcodes and bus types; addresses are 16 bits, so the core reaches 64 KB only.
package riscv_pkg;

  localparam int addr_width = 16;
  localparam int xlen = 32;

  localparam logic [addr_width-1:0] start_pc = 16'h4000;

  // Major opcodes of the supported subset.
  localparam logic [6:0] op_lui     = 7'b0110111;
  localparam logic [6:0] op_auipc   = 7'b0010111;
  localparam logic [6:0] op_jal     = 7'b1101111;
  localparam logic [6:0] op_jalr    = 7'b1100111;
  localparam logic [6:0] op_branch  = 7'b1100011;
  localparam logic [6:0] op_load    = 7'b0000011;
  localparam logic [6:0] op_store   = 7'b0100011;
  localparam logic [6:0] op_alu_imm = 7'b0010011;
  localparam logic [6:0] op_alu_reg = 7'b0110011;
  localparam logic [6:0] op_system  = 7'b1110011;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  // Branch offset bits are scattered across the word.
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [xlen-1:0]       wdata;
    logic [3:0]            byte_en;
    logic                  enable;
    logic                  write;
  } mem_req_t;

  // Branch mode turns funct3 into a compare condition.
  typedef struct packed {
    logic       branch_mode;
    logic [2:0] funct3;
    logic       alt;
  } alu_ctrl_t;

endpackage

// File: source/alu.sv
// Combinational ALU; shifts use the low five bits of operand_b and there is no multiply.
`timescale 1ns/1ps

module alu
(
  input  riscv_pkg::alu_ctrl_t alu_ctrl,
  input  logic [31:0]          operand_a,
  input  logic [31:0]          operand_b,
  output logic [31:0]          result,
  output logic                 branch_taken
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt = operand_b[4:0];
  assign lt_signed = $signed(operand_a) < $signed(operand_b);
  assign lt_unsigned = operand_a < operand_b;

  always_comb
  begin
    case (alu_ctrl.funct3)
      3'b000: result = alu_ctrl.alt ? operand_a - operand_b : operand_a + operand_b;
      3'b001: result = operand_a << shamt;
      3'b010: result = {31'd0, lt_signed};
      3'b011: result = {31'd0, lt_unsigned};
      3'b100: result = operand_a ^ operand_b;
      3'b101: result = alu_ctrl.alt ? $unsigned($signed(operand_a) >>> shamt)
                                    : operand_a >> shamt;
      3'b110: result = operand_a | operand_b;
      default: result = operand_a & operand_b;
    endcase
  end

  // Branch conditions, encoded as in the branch funct3.
  always_comb
  begin
    branch_taken = 1'b0;
    if (alu_ctrl.branch_mode)
      case (alu_ctrl.funct3)
        3'b000: branch_taken = (operand_a == operand_b);
        3'b001: branch_taken = (operand_a != operand_b);
        3'b100: branch_taken = lt_signed;
        3'b101: branch_taken = !lt_signed;
        3'b110: branch_taken = lt_unsigned;
        3'b111: branch_taken = !lt_unsigned;
        default: branch_taken = 1'b0;
      endcase
  end

endmodule

// File: source/register_file.sv
// Register file with x0 hardwired to zero; reads are combinational and contents are not reset.
`timescale 1ns/1ps

module register_file
(
  input  logic        raw_clk,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  logic        rd_we,
  input  logic [4:0]  rd_addr,
  input  logic [31:0] rd_wdata
);

  // Only x1 to x31 have storage.
  logic [31:0] regs [1:31];

  assign rs1_data = (rs1_addr == 5'd0) ? 32'h0000_0000 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? 32'h0000_0000 : regs[rs2_addr];

  always_ff @(posedge raw_clk)
  begin
    // Writes to x0 fall away here.
    if (rd_we && rd_addr != 5'd0)
      regs[rd_addr] <= rd_wdata;
  end

endmodule

// File: source/load_store_unit.sv
// Byte lane steering for loads and stores; misaligned halves and words are not detected.
`timescale 1ns/1ps

module load_store_unit
(
  input  logic [2:0]  funct3,
  input  logic [1:0]  ea_low,
  input  logic [31:0] store_data,
  input  logic [31:0] rdata,
  output logic [31:0] wdata,
  output logic [3:0]  byte_en,
  output logic [31:0] load_value
);

  logic [7:0]  load_byte;
  logic [15:0] load_half;
  logic        unsigned_load;

  assign unsigned_load = funct3[2];

  // Stores repeat the value on every lane; byte_en picks the real ones.
  always_comb
  begin
    case (funct3[1:0])
      2'b00:
      begin
        wdata = {4{store_data[7:0]}};
        byte_en = 4'b0001 << ea_low;
      end
      2'b01:
      begin
        wdata = {2{store_data[15:0]}};
        byte_en = ea_low[1] ? 4'b1100 : 4'b0011;
      end
      default:
      begin
        wdata = store_data;
        byte_en = 4'b1111;
      end
    endcase
  end

  assign load_byte = rdata[8*ea_low +: 8];
  assign load_half = ea_low[1] ? rdata[31:16] : rdata[15:0];

  // Sign fill is masked off for lbu and lhu.
  always_comb
  begin
    case (funct3[1:0])
      2'b00: load_value = {{24{load_byte[7] & ~unsigned_load}}, load_byte};
      2'b01: load_value = {{16{load_half[15] & ~unsigned_load}}, load_half};
      default: load_value = rdata;
    endcase
  end

endmodule

// File: source/core_control.sv
// Non-pipelined control FSM; it has no stall path and needs single-cycle memory reads.
`timescale 1ns/1ps

module core_control
(
  input  logic                 raw_clk,
  input  logic                 button_reset,
  input  logic                 button_halt,
  input  logic [31:0]          mem_rdata,
  output riscv_pkg::mem_req_t  mem_req,
  input  logic [31:0]          store_wdata,
  input  logic [3:0]           store_byte_en,
  input  logic [31:0]          load_value,
  output logic [2:0]           ls_funct3,
  output logic [1:0]           ea_low,
  output logic [4:0]           rs1_addr,
  output logic [4:0]           rs2_addr,
  input  logic [31:0]          rs1_data,
  input  logic [31:0]          rs2_data,
  output logic                 rd_we,
  output logic [4:0]           rd_addr,
  output logic [31:0]          rd_wdata,
  output riscv_pkg::alu_ctrl_t alu_ctrl,
  output logic [31:0]          operand_a,
  output logic [31:0]          operand_b,
  input  logic [31:0]          alu_result,
  input  logic                 branch_taken,
  output logic                 halted,
  output logic                 error
);

  typedef enum logic [3:0] {
    s_start, s_fetch, s_capture, s_decode, s_operand, s_writeback,
    s_branch, s_load, s_store, s_store_done, s_halted, s_error
  } state_t;

  state_t            state;
  riscv_pkg::instr_u instr;
  logic [15:0]       pc;
  logic [15:0]       pc_current;
  logic [15:0]       ea;
  logic [31:0]       result;

  logic [6:0]  opcode;
  logic [31:0] i_imm;
  logic [31:0] s_imm;
  logic [31:0] b_imm;
  logic [31:0] u_imm;
  logic [31:0] j_imm;
  logic [15:0] branch_target;
  logic [15:0] jal_target;

  assign opcode = instr.r.opcode;

  // Immediates from the format views.
  assign i_imm = {{20{instr.i.imm[11]}}, instr.i.imm};
  assign s_imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
  assign b_imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                  instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
  assign u_imm = {instr.u.imm_31_12, 12'h000};
  assign j_imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                  instr.j.imm_11, instr.j.imm_10_1, 1'b0};

  assign branch_target = pc_current + b_imm[15:0];
  assign jal_target    = pc_current + j_imm[15:0];

  assign rs1_addr  = instr.i.rs1;
  assign rs2_addr  = instr.s.rs2;
  assign rd_addr   = instr.r.rd;
  assign ls_funct3 = instr.i.funct3;
  assign ea_low    = ea[1:0];

  assign halted = (state == s_halted);
  assign error  = (state == s_error);

  // Operand and function select follow the held instruction.
  always_comb
  begin
    alu_ctrl.branch_mode = (opcode == riscv_pkg::op_branch);
    alu_ctrl.funct3 = 3'b000;
    alu_ctrl.alt = 1'b0;
    operand_a = rs1_data;
    operand_b = i_imm;
    case (opcode)
      riscv_pkg::op_alu_reg:
      begin
        alu_ctrl.funct3 = instr.r.funct3;
        alu_ctrl.alt = instr.r.funct7[5];
        operand_b = rs2_data;
      end
      riscv_pkg::op_alu_imm:
      begin
        alu_ctrl.funct3 = instr.i.funct3;
        // Only srai uses bit 30; addi has no subtract form.
        alu_ctrl.alt = (instr.i.funct3 == 3'b101) && instr.r.funct7[5];
      end
      riscv_pkg::op_branch:
      begin
        alu_ctrl.funct3 = instr.b.funct3;
        operand_b = rs2_data;
      end
      riscv_pkg::op_auipc:
      begin
        operand_a = {16'h0000, pc_current};
        operand_b = u_imm;
      end
      riscv_pkg::op_store:
        operand_b = s_imm;
      default:
        operand_b = i_imm;
    endcase
  end

  // Bus requests are driven straight from the state.
  always_comb
  begin
    mem_req = '0;
    case (state)
      s_fetch:
      begin
        mem_req.enable = 1'b1;
        mem_req.addr = pc;
      end
      s_decode:
        if (opcode == riscv_pkg::op_load)
        begin
          mem_req.enable = 1'b1;
          mem_req.addr = {alu_result[15:2], 2'b00};
        end
      s_store:
      begin
        mem_req.enable = 1'b1;
        mem_req.write = 1'b1;
        mem_req.addr = {ea[15:2], 2'b00};
        mem_req.wdata = store_wdata;
        mem_req.byte_en = store_byte_en;
      end
      default:
        mem_req = '0;
    endcase
  end

  // Register writeback source per phase.
  always_comb
  begin
    rd_we = 1'b0;
    rd_wdata = result;
    case (state)
      s_decode:
        case (opcode)
          riscv_pkg::op_lui:
          begin
            rd_we = 1'b1;
            rd_wdata = u_imm;
          end
          riscv_pkg::op_auipc:
          begin
            rd_we = 1'b1;
            rd_wdata = alu_result;
          end
          riscv_pkg::op_jal, riscv_pkg::op_jalr:
          begin
            // Link is the already advanced pc.
            rd_we = 1'b1;
            rd_wdata = {16'h0000, pc};
          end
          default:
            rd_we = 1'b0;
        endcase
      s_writeback:
        rd_we = 1'b1;
      s_load:
      begin
        rd_we = 1'b1;
        rd_wdata = load_value;
      end
      default:
        rd_we = 1'b0;
    endcase
  end

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state <= s_start;
      pc <= riscv_pkg::start_pc;
    end
    else if (!button_halt && state != s_error)
      state <= s_halted;
    else
      case (state)
        s_start:
          state <= s_fetch;
        s_fetch:
        begin
          pc_current <= pc;
          pc <= pc + 16'd4;
          state <= s_capture;
        end
        s_capture:
        begin
          instr <= mem_rdata;
          state <= s_decode;
        end
        s_decode:
          case (opcode)
            riscv_pkg::op_lui, riscv_pkg::op_auipc:
              state <= s_fetch;
            riscv_pkg::op_jal:
            begin
              pc <= jal_target;
              state <= s_fetch;
            end
            riscv_pkg::op_jalr:
            begin
              pc <= {alu_result[15:2], 2'b00};
              state <= s_fetch;
            end
            riscv_pkg::op_alu_imm:
            begin
              result <= alu_result;
              state <= s_writeback;
            end
            riscv_pkg::op_alu_reg:
              state <= s_operand;
            riscv_pkg::op_branch:
              state <= s_branch;
            riscv_pkg::op_load:
            begin
              ea <= alu_result[15:0];
              state <= s_load;
            end
            riscv_pkg::op_store:
            begin
              ea <= alu_result[15:0];
              state <= s_store;
            end
            riscv_pkg::op_system:
              state <= s_halted;
            default:
              state <= s_error;
          endcase
        s_operand:
        begin
          result <= alu_result;
          state <= s_writeback;
        end
        s_branch:
        begin
          if (branch_taken)
            pc <= branch_target;
          state <= s_fetch;
        end
        s_writeback, s_load, s_store_done:
          state <= s_fetch;
        s_store:
          state <= s_store_done;
        s_halted:
          state <= s_halted;
        default:
          state <= s_error;
      endcase
  end

endmodule

// File: source/riscv_core.sv
// Core top level; memory is external and must answer every read on the next clock edge.
`timescale 1ns/1ps

module riscv_core
(
  input  logic                raw_clk,
  input  logic                button_reset,
  input  logic                button_halt,
  output riscv_pkg::mem_req_t mem_req,
  input  logic [31:0]         mem_rdata,
  output logic                halted,
  output logic                error
);

  logic [31:0] store_wdata;
  logic [3:0]  store_byte_en;
  logic [31:0] load_value;
  logic [2:0]  ls_funct3;
  logic [1:0]  ea_low;

  logic [4:0]  rs1_addr;
  logic [4:0]  rs2_addr;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic        rd_we;
  logic [4:0]  rd_addr;
  logic [31:0] rd_wdata;

  riscv_pkg::alu_ctrl_t alu_ctrl;
  logic [31:0] operand_a;
  logic [31:0] operand_b;
  logic [31:0] alu_result;
  logic        branch_taken;

  core_control i_control
  (
    .raw_clk       (raw_clk),
    .button_reset  (button_reset),
    .button_halt   (button_halt),
    .mem_rdata     (mem_rdata),
    .mem_req       (mem_req),
    .store_wdata   (store_wdata),
    .store_byte_en (store_byte_en),
    .load_value    (load_value),
    .ls_funct3     (ls_funct3),
    .ea_low        (ea_low),
    .rs1_addr      (rs1_addr),
    .rs2_addr      (rs2_addr),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .rd_we         (rd_we),
    .rd_addr       (rd_addr),
    .rd_wdata      (rd_wdata),
    .alu_ctrl      (alu_ctrl),
    .operand_a     (operand_a),
    .operand_b     (operand_b),
    .alu_result    (alu_result),
    .branch_taken  (branch_taken),
    .halted        (halted),
    .error         (error)
  );

  register_file i_register_file
  (
    .raw_clk  (raw_clk),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd_we    (rd_we),
    .rd_addr  (rd_addr),
    .rd_wdata (rd_wdata)
  );

  alu i_alu
  (
    .alu_ctrl     (alu_ctrl),
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  load_store_unit i_load_store_unit
  (
    .funct3     (ls_funct3),
    .ea_low     (ea_low),
    .store_data (rs2_data),
    .rdata      (mem_rdata),
    .wdata      (store_wdata),
    .byte_en    (store_byte_en),
    .load_value (load_value)
  );

endmodule

// File: tests/program_table.svh
// Test programs for the core; each holds at most twelve words and expects stores near 16'h8000.

task automatic fill_program_table;
  for (int e = 0; e < num_entries; e++)
  begin
    exp_count[e] = 0;
    exp_error[e] = 1'b0;
    data_init[e] = '{32'h0000_0000, 32'h0000_0000};
  end

  // Register ALU ops with x2 = -7, x3 = 5.
  prog_words[0] = '{
    u_type(riscv_pkg::op_lui, 5'd1, 20'h00008),
    i_type(riscv_pkg::op_alu_imm, 3'b000, 5'd2, 5'd0, 12'hff9),
    i_type(riscv_pkg::op_alu_imm, 3'b000, 5'd3, 5'd0, 12'h005),
    r_type(7'h20, 5'd2, 5'd3, 3'b000, 5'd4),
    r_type(7'h00, 5'd3, 5'd2, 3'b010, 5'd5),
    r_type(7'h00, 5'd3, 5'd2, 3'b011, 5'd6),
    r_type(7'h00, 5'd3, 5'd2, 3'b101, 5'd7),
    s_type(3'b010, 5'd4, 5'd1, 12'd64),
    s_type(3'b010, 5'd5, 5'd1, 12'd68),
    s_type(3'b010, 5'd6, 5'd1, 12'd72),
    s_type(3'b010, 5'd7, 5'd1, 12'd76),
    i_type(riscv_pkg::op_system, 3'b000, 5'd0, 5'd0, 12'h001)
  };
  // sub gives 12, slt 1, sltu 0, srl by 5 drops the sign.
  expect_write(0, 16'h8040, 32'h0000_000c, 4'hf);
  expect_write(0, 16'h8044, 32'h0000_0001, 4'hf);
  expect_write(0, 16'h8048, 32'h0000_0000, 4'hf);
  expect_write(0, 16'h804c, 32'h07ff_ffff, 4'hf);

  // Immediate ops: srai, slli, sltiu, xori, then a store past ebreak.
  prog_words[1] = '{
    u_type(riscv_pkg::op_lui, 5'd1, 20'h00008),
    i_type(riscv_pkg::op_alu_imm, 3'b000, 5'd2, 5'd0, 12'hff9),
    i_type(riscv_pkg::op_alu_imm, 3'b101, 5'd3, 5'd2, 12'h401),
    i_type(riscv_pkg::op_alu_imm, 3'b001, 5'd4, 5'd2, 12'h004),
    i_type(riscv_pkg::op_alu_imm, 3'b011, 5'd5, 5'd2, 12'hfff),
    i_type(riscv_pkg::op_alu_imm, 3'b100, 5'd6, 5'd2, 12'h0ff),
    s_type(3'b010, 5'd3, 5'd1, 12'd64),
    s_type(3'b010, 5'd4, 5'd1, 12'd68),
    s_type(3'b010, 5'd5, 5'd1, 12'd72),
    s_type(3'b010, 5'd6, 5'd1, 12'd76),
    i_type(riscv_pkg::op_system, 3'b000, 5'd0, 5'd0, 12'h001),
    s_type(3'b010, 5'd2, 5'd1, 12'd80)
  };
  expect_write(1, 16'h8040, 32'hffff_fffc, 4'hf);
  expect_write(1, 16'h8044, 32'hffff_ff90, 4'hf);
  expect_write(1, 16'h8048, 32'h0000_0001, 4'hf);
  expect_write(1, 16'h804c, 32'hffff_ff06, 4'hf);

  // Byte stores on all four lanes and half stores on both halves of 0x12345678.
  // The run ends on an unknown opcode with one store behind it.
  prog_words[2] = '{
    u_type(riscv_pkg::op_lui, 5'd1, 20'h00008),
    u_type(riscv_pkg::op_lui, 5'd2, 20'h12345),
    i_type(riscv_pkg::op_alu_imm, 3'b000, 5'd2, 5'd2, 12'h678),
    s_type(3'b000, 5'd2, 5'd1, 12'd64),
    s_type(3'b000, 5'd2, 5'd1, 12'd65),
    s_type(3'b000, 5'd2, 5'd1, 12'd66),
    s_type(3'b000, 5'd2, 5'd1, 12'd67),
    s_type(3'b001, 5'd2, 5'd1, 12'd72),
    s_type(3'b001, 5'd2, 5'd1, 12'd74),
    32'h0000_000b,
    s_type(3'b010, 5'd2, 5'd1, 12'd80),
    32'h0000_0000
  };
  expect_write(2, 16'h8040, 32'h7878_7878, 4'b0001);
  expect_write(2, 16'h8040, 32'h7878_7878, 4'b0010);
  expect_write(2, 16'h8040, 32'h7878_7878, 4'b0100);
  expect_write(2, 16'h8040, 32'h7878_7878, 4'b1000);
  expect_write(2, 16'h8048, 32'h5678_5678, 4'b0011);
  expect_write(2, 16'h8048, 32'h5678_5678, 4'b1100);
  exp_error[2] = 1'b1;

  // lb, lbu, lh, lhu and lw of preset words, each stored back.
  data_init[3] = '{32'hc3a5_9e81, 32'h8765_4321};
  prog_words[3] = '{
    u_type(riscv_pkg::op_lui, 5'd1, 20'h00008),
    i_type(riscv_pkg::op_load, 3'b000, 5'd2, 5'd1, 12'd0),
    i_type(riscv_pkg::op_load, 3'b100, 5'd3, 5'd1, 12'd3),
    i_type(riscv_pkg::op_load, 3'b001, 5'd4, 5'd1, 12'd2),
    i_type(riscv_pkg::op_load, 3'b101, 5'd5, 5'd1, 12'd0),
    i_type(riscv_pkg::op_load, 3'b010, 5'd6, 5'd1, 12'd4),
    s_type(3'b010, 5'd2, 5'd1, 12'd64),
    s_type(3'b010, 5'd3, 5'd1, 12'd68),
    s_type(3'b010, 5'd4, 5'd1, 12'd72),
    s_type(3'b010, 5'd5, 5'd1, 12'd76),
    s_type(3'b010, 5'd6, 5'd1, 12'd80),
    i_type(riscv_pkg::op_system, 3'b000, 5'd0, 5'd0, 12'h001)
  };
  expect_write(3, 16'h8040, 32'hffff_ff81, 4'hf);
  expect_write(3, 16'h8044, 32'h0000_00c3, 4'hf);
  expect_write(3, 16'h8048, 32'hffff_c3a5, 4'hf);
  expect_write(3, 16'h804c, 32'h0000_9e81, 4'hf);
  expect_write(3, 16'h8050, 32'h8765_4321, 4'hf);

  // Branch pairs with x2 = 1, x3 = -1; the marker store runs only when not taken.
  prog_words[4] = '{
    u_type(riscv_pkg::op_lui, 5'd1, 20'h00008),
    i_type(riscv_pkg::op_alu_imm, 3'b000, 5'd2, 5'd0, 12'h001),
    i_type(riscv_pkg::op_alu_imm, 3'b000, 5'd3, 5'd0, 12'hfff),
    b_type(3'b000, 5'd2, 5'd2, 13'd8),
    s_type(3'b010, 5'd2, 5'd1, 12'd64),
    b_type(3'b000, 5'd2, 5'd3, 13'd8),
    s_type(3'b010, 5'd2, 5'd1, 12'd68),
    b_type(3'b001, 5'd2, 5'd3, 13'd8),
    s_type(3'b010, 5'd2, 5'd1, 12'd72),
    b_type(3'b001, 5'd2, 5'd2, 13'd8),
    s_type(3'b010, 5'd2, 5'd1, 12'd76),
    i_type(riscv_pkg::op_system, 3'b000, 5'd0, 5'd0, 12'h001)
  };
  prog_words[5] = prog_words[4];
  prog_words[5][3] = b_type(3'b100, 5'd3, 5'd2, 13'd8);
  prog_words[5][5] = b_type(3'b100, 5'd2, 5'd3, 13'd8);
  prog_words[5][7] = b_type(3'b101, 5'd2, 5'd3, 13'd8);
  prog_words[5][9] = b_type(3'b101, 5'd3, 5'd2, 13'd8);
  // Same operand pairs compared unsigned flip the outcome.
  prog_words[6] = prog_words[4];
  prog_words[6][3] = b_type(3'b110, 5'd2, 5'd3, 13'd8);
  prog_words[6][5] = b_type(3'b110, 5'd3, 5'd2, 13'd8);
  prog_words[6][7] = b_type(3'b111, 5'd3, 5'd2, 13'd8);
  prog_words[6][9] = b_type(3'b111, 5'd2, 5'd3, 13'd8);
  for (int e = 4; e <= 6; e++)
  begin
    expect_write(e, 16'h8044, 32'h0000_0001, 4'hf);
    expect_write(e, 16'h804c, 32'h0000_0001, 4'hf);
  end

  // jal over a store, jalr to an odd target, auipc there, lui, then an unknown opcode.
  prog_words[7] = '{
    u_type(riscv_pkg::op_lui, 5'd1, 20'h00008),
    j_type(5'd3, 21'd8),
    s_type(3'b010, 5'd2, 5'd1, 12'd96),
    i_type(riscv_pkg::op_jalr, 3'b000, 5'd4, 5'd3, 12'd13),
    s_type(3'b010, 5'd2, 5'd1, 12'd100),
    u_type(riscv_pkg::op_auipc, 5'd2, 20'h00001),
    s_type(3'b010, 5'd2, 5'd1, 12'd64),
    s_type(3'b010, 5'd3, 5'd1, 12'd68),
    s_type(3'b010, 5'd4, 5'd1, 12'd72),
    u_type(riscv_pkg::op_lui, 5'd5, 20'habcde),
    s_type(3'b010, 5'd5, 5'd1, 12'd76),
    32'h0000_000b
  };
  expect_write(7, 16'h8040, 32'(riscv_pkg::start_pc) + 32'h0000_1014, 4'hf);
  expect_write(7, 16'h8044, 32'(riscv_pkg::start_pc) + 32'h0000_0008, 4'hf);
  expect_write(7, 16'h8048, 32'(riscv_pkg::start_pc) + 32'h0000_0010, 4'hf);
  expect_write(7, 16'h804c, 32'habcd_e000, 4'hf);
  exp_error[7] = 1'b1;
endtask

// File: tests/tb_riscv_core.sv
// Testbench for riscv_core; memory answers every read in one cycle and halt is never pressed.
`timescale 1ns/1ps

module tb_riscv_core;

  localparam int num_entries = 8;
  localparam int max_words = 12;
  localparam int max_writes = 8;
  localparam int data_words = 2;
  localparam int mem_words = 16384;
  localparam int prog_base = int'(riscv_pkg::start_pc) / 4;
  localparam int data_base = 32'h0000_8000 / 4;
  localparam int timeout_cycles = num_entries * (max_words * 5 + 4) * 2;

  logic                raw_clk = 1'b0;
  logic                button_reset;
  logic                button_halt;
  riscv_pkg::mem_req_t mem_req;
  logic [31:0]         mem_rdata = 32'h0000_0000;
  logic                halted;
  logic                error;

  logic [31:0]         mem [mem_words];
  riscv_pkg::mem_req_t writes [$];
  logic                load_pending;
  int                  entry;
  int                  errors;
  int                  cycles = 0;

  // Program table storage.
  logic [31:0]         prog_words [num_entries][max_words];
  logic [31:0]         data_init [num_entries][data_words];
  riscv_pkg::mem_req_t exp_writes [num_entries][max_writes];
  int                  exp_count [num_entries];
  logic                exp_error [num_entries];

  riscv_core i_dut
  (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .button_halt  (button_halt),
    .mem_req      (mem_req),
    .mem_rdata    (mem_rdata),
    .halted       (halted),
    .error        (error)
  );

  always #4 raw_clk = ~raw_clk;

  // Instruction word builders over the format views.
  function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] funct3,
                                         input logic [4:0] rd);
    riscv_pkg::instr_u w;
    w = '0;
    w.r.funct7 = funct7;
    w.r.rs2 = rs2;
    w.r.rs1 = rs1;
    w.r.funct3 = funct3;
    w.r.rd = rd;
    w.r.opcode = riscv_pkg::op_alu_reg;
    return w;
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] opcode, input logic [2:0] funct3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    riscv_pkg::instr_u w;
    w = '0;
    w.i.imm = imm;
    w.i.rs1 = rs1;
    w.i.funct3 = funct3;
    w.i.rd = rd;
    w.i.opcode = opcode;
    return w;
  endfunction

  function automatic logic [31:0] s_type(input logic [2:0] funct3, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [11:0] imm);
    riscv_pkg::instr_u w;
    w = '0;
    w.s.imm_11_5 = imm[11:5];
    w.s.rs2 = rs2;
    w.s.rs1 = rs1;
    w.s.funct3 = funct3;
    w.s.imm_4_0 = imm[4:0];
    w.s.opcode = riscv_pkg::op_store;
    return w;
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] funct3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] imm);
    riscv_pkg::instr_u w;
    w = '0;
    w.b.imm_12 = imm[12];
    w.b.imm_10_5 = imm[10:5];
    w.b.rs2 = rs2;
    w.b.rs1 = rs1;
    w.b.funct3 = funct3;
    w.b.imm_4_1 = imm[4:1];
    w.b.imm_11 = imm[11];
    w.b.opcode = riscv_pkg::op_branch;
    return w;
  endfunction

  function automatic logic [31:0] u_type(input logic [6:0] opcode, input logic [4:0] rd,
                                         input logic [19:0] imm);
    riscv_pkg::instr_u w;
    w = '0;
    w.u.imm_31_12 = imm;
    w.u.rd = rd;
    w.u.opcode = opcode;
    return w;
  endfunction

  function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
    riscv_pkg::instr_u w;
    w = '0;
    w.j.imm_20 = imm[20];
    w.j.imm_10_1 = imm[10:1];
    w.j.imm_11 = imm[11];
    w.j.imm_19_12 = imm[19:12];
    w.j.rd = rd;
    w.j.opcode = riscv_pkg::op_jal;
    return w;
  endfunction

  task automatic expect_write(input int e, input logic [15:0] addr, input logic [31:0] data,
                              input logic [3:0] byte_en);
    riscv_pkg::mem_req_t w;
    w.addr = addr;
    w.wdata = data;
    w.byte_en = byte_en;
    w.enable = 1'b1;
    w.write = 1'b1;
    exp_writes[e][exp_count[e]] = w;
    exp_count[e] = exp_count[e] + 1;
  endtask

  `include "program_table.svh"

  // Fill pattern decodes as an unknown opcode, so a runaway fetch ends in error.
  task automatic preset_memory(input int e);
    logic [15:0] byte_addr;
    for (int i = 0; i < mem_words; i++)
    begin
      byte_addr = 16'(i * 4);
      mem[i] = {~byte_addr, byte_addr};
    end
    for (int k = 0; k < max_words; k++)
      mem[prog_base + k] = prog_words[e][k];
    for (int k = 0; k < data_words; k++)
      mem[data_base + k] = data_init[e][k];
    writes.delete();
  endtask

  // Single-cycle memory; every write is also logged.
  always @(posedge raw_clk)
  begin
    if (load_pending)
      preset_memory(entry);
    else if (mem_req.enable)
    begin
      if (mem_req.write)
      begin
        for (int b = 0; b < 4; b++)
          if (mem_req.byte_en[b])
            mem[mem_req.addr[15:2]][8*b +: 8] = mem_req.wdata[8*b +: 8];
        writes.push_back(mem_req);
      end
      else
        mem_rdata <= mem[mem_req.addr[15:2]];
    end
  end

  always @(posedge raw_clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles)
    begin
      $display("simulation timed out before all programs finished");
      $display("errors: %0d", errors);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // Memory is reloaded on the first reset cycle.
  task automatic apply_reset;
    button_reset = 1'b0;
    load_pending = 1'b1;
    @(posedge raw_clk);
    #1;
    load_pending = 1'b0;
    repeat (3) @(posedge raw_clk);
    #1;
    button_reset = 1'b1;
  endtask

  task automatic wait_for_stop;
    while (!(halted || error))
    begin
      @(posedge raw_clk);
      #1;
    end
  endtask

  task automatic check_entry(input int e);
    int                  n;
    riscv_pkg::mem_req_t got;
    riscv_pkg::mem_req_t want;
    n = (writes.size() < exp_count[e]) ? writes.size() : exp_count[e];
    assert (writes.size() == exp_count[e])
    else
    begin
      errors = errors + 1;
      $display("mismatch at %0t: entry %0d write count %0d, expected %0d",
               $time, e, writes.size(), exp_count[e]);
    end
    for (int k = 0; k < n; k++)
    begin
      got = writes[k];
      want = exp_writes[e][k];
      assert (got.addr == want.addr)
      else
      begin
        errors = errors + 1;
        $display("mismatch at %0t: entry %0d write %0d addr %h, expected %h",
                 $time, e, k, got.addr, want.addr);
      end
      assert (got.wdata == want.wdata)
      else
      begin
        errors = errors + 1;
        $display("mismatch at %0t: entry %0d write %0d wdata %h, expected %h",
                 $time, e, k, got.wdata, want.wdata);
      end
      assert (got.byte_en == want.byte_en)
      else
      begin
        errors = errors + 1;
        $display("mismatch at %0t: entry %0d write %0d byte_en %b, expected %b",
                 $time, e, k, got.byte_en, want.byte_en);
      end
    end
    assert (halted == !exp_error[e] && error == exp_error[e])
    else
    begin
      errors = errors + 1;
      $display("mismatch at %0t: entry %0d status halted %b error %b, expected error %b",
               $time, e, halted, error, exp_error[e]);
    end
  endtask

  initial
  begin
    button_reset = 1'b0;
    button_halt = 1'b1;
    load_pending = 1'b0;
    entry = 0;
    errors = 0;
    fill_program_table();
    for (int e = 0; e < num_entries; e++)
    begin
      entry = e;
      apply_reset();
      wait_for_stop();
      // A few idle cycles show that nothing follows the stop.
      repeat (4) @(posedge raw_clk);
      #1;
      check_entry(e);
    end
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: riscv_core.f
+incdir+tests
source/riscv_pkg.sv
source/alu.sv
source/register_file.sv
source/load_store_unit.sv
source/core_control.sv
source/riscv_core.sv
tests/tb_riscv_core.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for a pass.
set -u
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert --top-module tb_riscv_core \
  -f riscv_core.f -o sim_riscv_core > "$build_log" 2>&1
if [ $? -ne 0 ]; then
  cat "$build_log"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_riscv_core > "$sim_log" 2>&1
if [ $? -ne 0 ]; then
  cat "$sim_log"
  echo "Simulation exited with a non-zero status"
  exit 1
fi
cat "$sim_log"

if grep -q "^TEST RESULT: PASS$" "$sim_log"; then
  exit 0
fi
echo "Pass line not found in $sim_log"
exit 1
